/* common/botTypesPkg.sv */
package botTypesPkg;

    // one boolean function of 7 variables as a truth-table mask
    localparam int botBits = 128;

    // batch result widths, as seen at the pipeline output
    localparam int sumBits   = 40;
    localparam int countBits = 5;

    // term range is 0 to 128, so 8 bits
    localparam int termBits = 8;

    typedef logic [botBits-1:0]   botWord;   // used for both top and bot
    typedef logic [termBits-1:0]  termWord;  // bits set in top and clear in bot
    typedef logic [sumBits-1:0]   sumWord;   // exact sum of a batch's terms
    typedef logic [countBits-1:0] countWord; // valid bots per batch, wraps mod 32

endpackage

/* common/pipeCtrlPkg.sv */
package pipeCtrlPkg;

    // entry layout, msb first: close flag, valid flag, term
    localparam int entryWidth = 10;
    localparam int closeBit   = 9;   // batch-close marker
    localparam int validBit   = 8;   // bot passed the subset test
    localparam int termMsb    = 7;   // term occupies [termMsb:0]

    typedef logic [entryWidth-1:0] fifoEntry;

    // accIdle has no batch open, accOpen collects, accEmit holds a result
    typedef enum logic [1:0] {
        accIdle,
        accOpen,
        accEmit
    } accState;

endpackage

/* rtl/subsetFilter/subsetFilter.sv */
`timescale 1ns/1ns

module subsetFilter (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 ivalid,
    input  logic                 startNewTop,
    input  botTypesPkg::botWord  bot,
    output logic                 iready,
    output logic                 pushValid,
    output pipeCtrlPkg::fifoEntry pushEntry,
    input  logic                 pushReady
);

    import botTypesPkg::*;
    import pipeCtrlPkg::*;

    botWord  topReg;     // current top function
    logic    topLoaded;  // a top has arrived since reset
    logic    botSeen;    // at least one bot since the last top
    logic    active;     // low during reset and the cycle after it

    botWord  extraBits;  // set in bot but clear in top
    botWord  keptBits;   // set in top and clear in bot
    logic    isSubset;
    termWord termCount;
    logic    inFire;

    // stage is free when empty or when its entry leaves this cycle
    assign iready = active && (!pushValid || pushReady);
    assign inFire = ivalid && iready;

    assign extraBits = bot & ~topReg;
    assign keptBits  = topReg & ~bot;
    assign isSubset  = topLoaded && (extraBits == '0); // no top yet means no subset

    // population count, always taken, zeroed later for non-subset bots
    always_comb begin
        termCount = '0;
        for (int i = 0; i < botBits; i++) begin
            termCount = termCount + termWord'(keptBits[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            active    <= 1'b0;
            pushValid <= 1'b0;
            topReg    <= '0;
            topLoaded <= 1'b0;
            botSeen   <= 1'b0;
        end else begin
            active <= 1'b1;
            if (inFire) begin
                if (startNewTop) begin
                    topReg    <= bot;
                    topLoaded <= 1'b1;
                    botSeen   <= 1'b0;
                    pushValid <= botSeen; // close only if the old batch had bots
                end else begin
                    botSeen   <= 1'b1;
                    pushValid <= 1'b1;
                end
            end else if (pushReady) begin
                pushValid <= 1'b0;
            end
        end
    end

    // payload of the single register stage
    always_ff @(posedge clock) begin
        if (inFire) begin
            pushEntry[closeBit] <= startNewTop;
            pushEntry[validBit] <= !startNewTop && isSubset;
            if (!startNewTop && isSubset) begin
                pushEntry[termMsb:0] <= termCount;
            end else begin
                pushEntry[termMsb:0] <= '0;
            end
        end
    end

    // a close marker never also carries a valid term
    assert property (@(posedge clock) disable iff (!rst)
        pushValid |-> !(pushEntry[closeBit] && pushEntry[validBit]))
        else $error("subsetFilter: entry marked both close and valid");

endmodule

/* rtl/termFifo.sv */
`timescale 1ns/1ns

module termFifo #(
    parameter int fifoDepth = 8
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  pushValid,
    input  pipeCtrlPkg::fifoEntry pushEntry,
    output logic                  pushReady,
    output logic                  popValid,
    output pipeCtrlPkg::fifoEntry popEntry,
    input  logic                  popReady
);

    import pipeCtrlPkg::*;

    localparam int ptrWidth = $clog2(fifoDepth);

    // depth check at elaboration
    if (fifoDepth < 2 || (fifoDepth & (fifoDepth - 1)) != 0) begin : gDepthCheck
        $error("termFifo: fifoDepth must be a power of two, at least 2");
    end

    fifoEntry mem [fifoDepth];

    logic [ptrWidth:0] wrPtr;     // extra msb tells full from empty
    logic [ptrWidth:0] rdPtr;
    logic [ptrWidth:0] occupancy;
    logic              full;
    logic              empty;
    logic              pushFire;
    logic              popFire;

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[ptrWidth] != rdPtr[ptrWidth]) &&
                   (wrPtr[ptrWidth-1:0] == rdPtr[ptrWidth-1:0]);
    assign occupancy = wrPtr - rdPtr;

    assign popValid  = !empty;
    assign pushReady = !full || popReady; // a full FIFO still takes a push when one leaves

    assign pushFire = pushValid && pushReady;
    assign popFire  = popValid && popReady;

    assign popEntry = mem[rdPtr[ptrWidth-1:0]];

    always_ff @(posedge clock) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (pushFire) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popFire) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pushFire) begin
            mem[wrPtr[ptrWidth-1:0]] <= pushEntry;
        end
    end

    // no push while full, seen as the pointers never drifting past the depth
    assert property (@(posedge clock) disable iff (!rst)
        occupancy <= fifoDepth)
        else $error("termFifo: overflow, occupancy %0d", occupancy);

    // no pop while empty; an entry only leaves once it has been pushed
    assert property (@(posedge clock) disable iff (!rst)
        popFire |-> $past(pushFire) || (occupancy > 1) || !$past(empty))
        else $error("termFifo: pop from an empty FIFO");

endmodule

/* rtl/batchAccumulator/batchAccumulator.sv */
`timescale 1ns/1ns

module batchAccumulator (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  popValid,
    input  pipeCtrlPkg::fifoEntry popEntry,
    output logic                  popReady,
    output logic                  ovalid,
    input  logic                  oready,
    output botTypesPkg::sumWord   summedData,
    output botTypesPkg::countWord pcoeffCount
);

    import botTypesPkg::*;
    import pipeCtrlPkg::*;

    accState  state;
    accState  nextState;
    sumWord   runSum;    // running sum of the open batch
    countWord runCount;  // wraps modulo 32 by width
    logic     popFire;
    logic     isClose;
    logic     isValid;
    termWord  entryTerm;

    assign popReady = (state != accEmit); // stall the FIFO while a result waits
    assign popFire  = popValid && popReady;
    assign ovalid   = (state == accEmit);

    assign isClose   = popEntry[closeBit];
    assign isValid   = popEntry[validBit];
    assign entryTerm = popEntry[termMsb:0];

    always_comb begin
        nextState = state;
        case (state)
            accIdle, accOpen: begin
                if (popFire) begin
                    if (isClose) begin
                        nextState = accEmit;
                    end else begin
                        nextState = accOpen; // subset or not, the batch is now open
                    end
                end
            end
            accEmit: begin
                if (oready) begin
                    nextState = accIdle; // result taken
                end
            end
            default: begin
                nextState = accIdle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            state    <= accIdle;
            runSum   <= '0;
            runCount <= '0;
        end else begin
            state <= nextState;
            if (popFire) begin
                if (isClose) begin
                    runSum   <= '0;
                    runCount <= '0;
                end else if (isValid) begin
                    runSum   <= runSum + sumWord'(entryTerm);
                    runCount <= runCount + 1'b1;
                end
            end
        end
    end

    // result registers, loaded once per closed batch
    always_ff @(posedge clock) begin
        if (popFire && isClose) begin
            summedData  <= runSum;
            pcoeffCount <= runCount;
        end
    end

    // held result must not move until the consumer takes it
    assert property (@(posedge clock) disable iff (!rst)
        ovalid && !oready |=> ovalid && $stable(summedData) && $stable(pcoeffCount))
        else $error("batchAccumulator: result changed while stalled");

    // the filter only closes a batch that received at least one bot
    assert property (@(posedge clock) disable iff (!rst)
        popFire && isClose |-> state == accOpen)
        else $error("batchAccumulator: close entry with no open batch");

endmodule

/* rtl/pcoeffPipeline.sv */
`timescale 1ns/1ns

module pcoeffPipeline #(
    parameter int fifoDepth = 8
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  ivalid,
    input  logic                  startNewTop,
    input  botTypesPkg::botWord   bot,
    output logic                  iready,
    output logic                  ovalid,
    input  logic                  oready,
    output botTypesPkg::sumWord   summedData,
    output botTypesPkg::countWord pcoeffCount
);

    import pipeCtrlPkg::*;

    // producer to buffer
    logic     pushValid;
    logic     pushReady;
    fifoEntry pushEntry;

    // buffer to consumer
    logic     popValid;
    logic     popReady;
    fifoEntry popEntry;

    subsetFilter filter (
        .clock      (clock),
        .rst        (rst),
        .ivalid     (ivalid),
        .startNewTop(startNewTop),
        .bot        (bot),
        .iready     (iready),
        .pushValid  (pushValid),
        .pushEntry  (pushEntry),
        .pushReady  (pushReady)
    );

    termFifo #(
        .fifoDepth(fifoDepth)
    ) fifo (
        .clock    (clock),
        .rst      (rst),
        .pushValid(pushValid),
        .pushEntry(pushEntry),
        .pushReady(pushReady),
        .popValid (popValid),
        .popEntry (popEntry),
        .popReady (popReady)
    );

    batchAccumulator accumulator (
        .clock      (clock),
        .rst        (rst),
        .popValid   (popValid),
        .popEntry   (popEntry),
        .popReady   (popReady),
        .ovalid     (ovalid),
        .oready     (oready),
        .summedData (summedData),
        .pcoeffCount(pcoeffCount)
    );

endmodule

/* dv/pcoeffChecker.sv */
`timescale 1ns/1ns

module pcoeffChecker (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  ovalid,
    input  logic                  oready,
    input  botTypesPkg::sumWord   summedData,
    input  botTypesPkg::countWord pcoeffCount
);

    import botTypesPkg::*;

    sumWord   expSums [$];   // oldest closed batch first
    countWord expCounts [$];
    sumWord   wantSum;
    countWord wantCount;
    string    testName;
    int       testNumber   = 0;
    int       testErrors   = 0;
    int       testResults  = 0;
    int       testsPassed  = 0;
    int       testsFailed  = 0;
    int       totalResults = 0;

    task automatic startTest(input string name);
        testNumber++;
        testName    = name;
        testErrors  = 0;
        testResults = 0;
    endtask

    task automatic expectResult(input sumWord sum, input countWord count);
        expSums.push_back(sum);
        expCounts.push_back(count);
    endtask

    function automatic int pendingCount();
        return expSums.size();
    endfunction

    task automatic discardPending();
        expSums.delete();
        expCounts.delete();
    endtask

    task automatic reportProblem(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        testErrors++;
    endtask

    task automatic checkEqual(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic closeTest();
        if (expSums.size() != 0) begin
            reportProblem($sformatf("%0d expected results never arrived", expSums.size()));
            discardPending();
        end
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %0d (%s): ok, %0d results", testNumber, testName, testResults);
        end else begin
            testsFailed++;
            $display("test %0d (%s): failed with %0d errors", testNumber, testName, testErrors);
        end
    endtask

    task automatic printTotals();
        $display("totals: %0d tests, %0d passed, %0d failed, %0d results checked",
                 testNumber, testsPassed, testsFailed, totalResults);
    endtask

    function automatic int failedTests();
        return testsFailed;
    endfunction

    // outputs settle after the rising edge, so the falling edge sees the transfer values
    always @(negedge clock) begin
        if (rst && ovalid && oready) begin
            totalResults++;
            testResults++;
            if (expSums.size() == 0) begin
                reportProblem($sformatf("result arrived that was not expected, sum %0d count %0d",
                                        summedData, pcoeffCount));
            end else begin
                wantSum   = expSums.pop_front();
                wantCount = expCounts.pop_front();
                if (summedData !== wantSum) begin
                    $display("CHECK FAILED at %0t ns: batch sum expected %0d, got %0d",
                             $time, wantSum, summedData);
                    testErrors++;
                end
                if (pcoeffCount !== wantCount) begin
                    $display("CHECK FAILED at %0t ns: pcoeff count expected %0d, got %0d",
                             $time, wantCount, pcoeffCount);
                    testErrors++;
                end
            end
        end
    end

endmodule

/* dv/pcoeffPipelineTb.sv */
`timescale 1ns/1ns

module pcoeffPipelineTb;

    import botTypesPkg::*;

    // words and results over all tests, tests 1 to 6 with test 6 split at its reset
    localparam int totalWords   = 34 + 40 + 83 + 11 + 65 + 14 + 15;
    localparam int totalResults = 3 + 3 + 2 + 1 + 4 + 1 + 2;
    localparam int cycleLimit   = (totalWords + totalResults) * 4 + 200;

    logic        clock = 1'b0;
    logic        rst;
    logic        ivalid;
    logic        startNewTop;
    botWord      bot;
    logic        iready;
    logic        ovalid;
    logic        oready;
    sumWord      summedData;
    countWord    pcoeffCount;

    logic [31:0] lfsrState  = 32'h1cb01827;
    logic [31:0] stallState = 32'h1cb01827;  // separate stream for oready
    botWord      batchBots [64];
    int          cycleCount    = 0;
    int          acceptedWords = 0;
    logic        stallOutput   = 1'b0;
    int          stallLen      = 1;
    int          phaseLeft     = 0;

    pcoeffPipeline #(
        .fifoDepth(8)
    ) DUT (
        .clock      (clock),
        .rst        (rst),
        .ivalid     (ivalid),
        .startNewTop(startNewTop),
        .bot        (bot),
        .iready     (iready),
        .ovalid     (ovalid),
        .oready     (oready),
        .summedData (summedData),
        .pcoeffCount(pcoeffCount)
    );

    pcoeffChecker resultChecker (
        .clock      (clock),
        .rst        (rst),
        .ovalid     (ovalid),
        .oready     (oready),
        .summedData (summedData),
        .pcoeffCount(pcoeffCount)
    );

    always #20 clock = ~clock;

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic takeBit();
        lfsrState = lfsrStep(lfsrState);
        return lfsrState[0];
    endfunction

    function automatic logic takeStallBit();
        stallState = lfsrStep(stallState);
        return stallState[0];
    endfunction

    function automatic botWord randomWord();
        botWord w;
        for (int i = 0; i < botBits; i++) begin
            w[i] = takeBit();
        end
        return w;
    endfunction

    // subset bots add the bits they clear in top, and one to the 5-bit count
    function automatic void referenceBatch(input botWord top, input int numBots,
                                           output sumWord sum, output countWord count);
        botWord rest;
        sum   = '0;
        count = '0;
        for (int b = 0; b < numBots; b++) begin
            if ((batchBots[b] & ~top) == '0) begin
                rest = top & ~batchBots[b];
                for (int i = 0; i < botBits; i++) begin
                    sum = sum + rest[i];
                end
                count = count + 1'b1;
            end
        end
    endfunction

    task automatic sendWord(input logic isTop, input botWord word);
        logic taken;
        ivalid      = 1'b1;
        startNewTop = isTop;
        bot         = word;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = iready;  // iready comes from registers only
            @(posedge clock);
            #2;
        end
    endtask

    task automatic runBatches(input int numBatches, input int botsPerBatch, input logic mixed);
        botWord   top;
        sumWord   sum;
        countWord count;
        for (int b = 0; b < numBatches; b++) begin
            top = randomWord();
            sendWord(1'b1, top);
            for (int i = 0; i < botsPerBatch; i++) begin
                if (mixed && takeBit()) begin
                    batchBots[i] = randomWord();  // almost never a subset
                end else begin
                    batchBots[i] = top & randomWord();
                end
                sendWord(1'b0, batchBots[i]);
            end
            referenceBatch(top, botsPerBatch, sum, count);
            resultChecker.expectResult(sum, count);
        end
        sendWord(1'b1, randomWord());  // closes the last batch
        ivalid = 1'b0;
    endtask

    task automatic finishTest();
        while (resultChecker.pendingCount() != 0) begin
            @(posedge clock);
            #2;
        end
        repeat (4) @(posedge clock);
        #2;
        resultChecker.closeTest();
    endtask

    task automatic applyReset();
        ivalid = 1'b0;
        rst    = 1'b0;
        repeat (16) @(posedge clock);
        #2;
        rst = 1'b1;
    endtask

    // input transfers counted apart from the driver
    always @(negedge clock) begin
        if (rst && ivalid && iready) begin
            acceptedWords++;
        end
    end

    // low and high stretches of equal length, so at most half the cycles stall
    always begin
        @(posedge clock);
        #2;
        if (!stallOutput) begin
            oready    = 1'b1;
            phaseLeft = 0;
        end else if (phaseLeft == 0) begin
            if (oready) begin
                stallLen = 1;
                for (int k = 0; k < 4; k++) begin
                    if (takeStallBit()) begin
                        stallLen = stallLen + (1 << k);
                    end
                end
                oready = 1'b0;
            end else begin
                oready = 1'b1;
            end
            phaseLeft = stallLen - 1;
        end else begin
            phaseLeft = phaseLeft - 1;
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no finish after %0d cycles", cycleCount);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int wordsBefore;
        startNewTop = 1'b0;
        bot         = '0;
        oready      = 1'b1;
        applyReset();

        resultChecker.startTest("subset bots under one top");
        runBatches(3, 10, 1'b0);
        finishTest();

        resultChecker.startTest("mixed subset and non-subset bots");
        runBatches(3, 12, 1'b1);
        finishTest();

        resultChecker.startTest("count wraps past 31 bots");
        runBatches(2, 40, 1'b0);
        finishTest();

        resultChecker.startTest("consecutive tops and empty batches");
        for (int i = 0; i < 3; i++) begin
            sendWord(1'b1, randomWord());
        end
        runBatches(1, 5, 1'b1);
        sendWord(1'b1, randomWord());
        ivalid = 1'b0;
        finishTest();

        resultChecker.startTest("output back-pressure");
        stallOutput = 1'b1;
        wordsBefore = acceptedWords;
        runBatches(4, 15, 1'b1);
        resultChecker.checkEqual("accepted words", 65, acceptedWords - wordsBefore);
        finishTest();
        stallOutput = 1'b0;

        resultChecker.startTest("reset in mid-stream");
        runBatches(1, 8, 1'b0);
        for (int i = 0; i < 4; i++) begin
            sendWord(1'b0, randomWord());  // open batch lost to the reset
        end
        applyReset();
        resultChecker.discardPending();
        runBatches(2, 6, 1'b1);
        finishTest();

        resultChecker.printTotals();
        if (resultChecker.failedTests() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src.f */
common/botTypesPkg.sv
common/pipeCtrlPkg.sv
rtl/subsetFilter/subsetFilter.sv
rtl/termFifo.sv
rtl/batchAccumulator/batchAccumulator.sv
rtl/pcoeffPipeline.sv
dv/pcoeffChecker.sv
dv/pcoeffPipelineTb.sv
